/* verification/fm_post_vectors.txt */
# T passes bias diff ref_init | S lane0..lane5 psum, 32-bit two's complement, lane 0 first
# E byte0..byte5 guard_mask, one line per position; every field is hex
# tile 0: one pass, no bias, clipping, saturation and guard bits
T 1 00 0 0
S 00000000 00000001 0000007f 00000080 000000ff 00000100
S ffffffff 00000005 7fffffff 80000000 00000042 00000000
S 00000010 00000020 00000030 00000040 00000050 00000060
S 000003e8 fffffc18 0000000c 000000c8 00000000 00000001
E 00 01 7f 80 ff ff 3e
E 00 05 ff 00 42 00 16
E 10 20 30 40 50 60 3f
E ff 00 0c c8 00 01 2d
# tile 1: two passes plus bias, delta mode with reference init
T 2 0a 1 1
S 00000010 00000020 ffffff00 00000064 00000001 000000c8
S 00000000 00000000 00000000 00000000 00000000 00000000
S 00000100 00000050 00000030 fffffff6 00000003 00000011
S fffffff6 00000002 00000003 00000004 00000005 00000006
S 00000005 00000005 00000005 00000064 fffffff0 00000064
S 00000000 00000001 fffffff6 00000080 00000070 ffffff9c
S 00000000 00000050 00000030 00000000 00000004 00000022
S 00000000 00000002 00000003 00000004 00000005 00000006
E 1f 2f 00 d2 00 ff 2b
E 0a 0b 00 8a 7a 00 1b
E ff aa 6a 00 11 3d 37
E 00 0e 10 12 14 16 3e
# tile 2: one pass with bias, delta against the references left by tile 1
T 1 03 1 0
S 00000000 00000010 fffffff0 00000005 0000000a 00000100
S 00000001 ffffffe0 00000064 000000c8 fffffff0 00000040
S 000000fd 00000000 00000000 00000000 00000000 0000000a
S 00000005 00000000 ffffffe0 00000020 00000001 fffffff9
E 03 13 00 00 08 ff 33
E 04 00 67 55 00 00 0d
E ff 00 03 03 03 0d 3d
E 08 03 00 23 04 00 1b

/* verilog.f */
common/fm_post_pkg.sv
common/tile_ctrl_if.sv
source/tile_counter.sv
source/tile_fsm.sv
psum/psum_accum.sv
writeback/diff_relu.sv
writeback/write_back.sv
source/fm_post_top.sv
verification/fm_post_props.sv
verification/fm_post_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then decide on the log contents
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module fm_post_tb \
    -Mdir obj_dir -o fm_post_sim \
    && ./obj_dir/fm_post_sim > sim.log 2>&1 \
    || echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && echo "simulation failed" && exit 1 || echo "simulation passed"

/* verification/fm_post_tb.sv */
// testbench for the post stage that plays the vector file into the DUT and checks every output
`timescale 1ns/10ps
module fm_post_tb
    import fm_post_pkg::*;
();

    localparam int          TILE_DEPTH   = 4;
    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 5;
    localparam int          MAX_GAP      = 3;     // most idle cycles before a strobe
    localparam int          DRAIN_CYCLES = TILE_DEPTH * NUM_LANES + 2;
    localparam logic [31:0] SEED         = 32'hcfbeb96a;
    localparam string       VEC_FILE     = "verification/fm_post_vectors.txt";

    logic                            clk;
    logic                            rst_n;
    logic                            psum_valid_i;
    logic [NUM_LANES*PSUM_WIDTH-1:0] psum_i;
    pass_t                           pass_num_i;
    pixel_t                          bias_i;
    logic                            diff_mode_i;
    logic                            ref_init_i;
    pixel_t                          wb_data_o;
    logic                            wb_valid_o;
    lane_mask_t                      guard_o;
    logic                            guard_valid_o;
    logic                            wb_finish_o;

    // per-tile header fields followed by flat strobe and expected queues
    int                              tile_passes [$];
    pixel_t                          tile_bias [$];
    logic                            tile_diff [$];
    logic                            tile_init [$];
    int                              tile_strobes [$];
    logic [NUM_LANES*PSUM_WIDTH-1:0] strobe_q [$];
    pixel_t                          exp_byte_q [$];
    lane_mask_t                      exp_guard_q [$];

    int   byte_idx        = 0;
    int   guard_idx       = 0;
    int   tile_bytes      = 0;    // reset on every finish pulse
    int   tile_guards     = 0;
    int   finish_cnt      = 0;
    int   watchdog_cycles = 0;
    logic vectors_loaded  = 1'b0;
    logic valid_prev      = 1'b0;  // wb_valid_o one cycle earlier

    fm_post_top #(.TILE_DEPTH(TILE_DEPTH)) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .psum_valid_i  (psum_valid_i),
        .psum_i        (psum_i),
        .pass_num_i    (pass_num_i),
        .bias_i        (bias_i),
        .diff_mode_i   (diff_mode_i),
        .ref_init_i    (ref_init_i),
        .wb_data_o     (wb_data_o),
        .wb_valid_o    (wb_valid_o),
        .guard_o       (guard_o),
        .guard_valid_o (guard_valid_o),
        .wb_finish_o   (wb_finish_o)
    );

    bind fm_post_top fm_post_props #(.TILE_DEPTH(TILE_DEPTH)) i_props (
        .clk           (clk),
        .rst_n         (rst_n),
        .psum_valid_i  (psum_valid_i),
        .pass_num_i    (pass_num_i),
        .wb_data_o     (wb_data_o),
        .wb_valid_o    (wb_valid_o),
        .guard_o       (guard_o),
        .guard_valid_o (guard_valid_o),
        .wb_finish_o   (wb_finish_o)
    );

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, got, expected);
            stop_on_error();
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        int          l;
        string       line;
        string       rest;
        logic [31:0] f [7];
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open vector file %s", VEC_FILE);
            stop_on_error();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            rest = line.substr(1, line.len() - 1);
            case (line.getc(0))
                "T": begin
                    n = $sscanf(rest, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                    tile_passes.push_back(int'(f[0]));
                    tile_bias.push_back(pixel_t'(f[1]));
                    tile_diff.push_back(f[2][0]);
                    tile_init.push_back(f[3][0]);
                    tile_strobes.push_back(0);
                end
                "S": begin
                    n = $sscanf(rest, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    strobe_q.push_back({f[5], f[4], f[3], f[2], f[1], f[0]});   // lane 0 low
                    tile_strobes[tile_strobes.size() - 1]++;
                end
                "E": begin
                    n = $sscanf(rest, "%h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    for (l = 0; l < NUM_LANES; l++) begin
                        exp_byte_q.push_back(pixel_t'(f[l]));
                    end
                    exp_guard_q.push_back(lane_mask_t'(f[6]));
                end
                default: begin
                    $display("Vector file has a line of unknown kind: %s", line);
                    stop_on_error();
                end
            endcase
        end
        $fclose(fd);
        foreach (tile_passes[t]) begin
            if (tile_strobes[t] != tile_passes[t] * TILE_DEPTH) begin
                $display("Vector file tile %0d holds %0d strobes instead of %0d",
                         t, tile_strobes[t], tile_passes[t] * TILE_DEPTH);
                stop_on_error();
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // driver with random gaps between strobes, each tile end held until the previous drain is done
    initial begin
        int unsigned gap;
        int          sidx;
        void'($urandom(SEED));
        rst_n        = 1'b0;
        psum_valid_i = 1'b0;
        psum_i       = '0;
        pass_num_i   = 8'd1;
        bias_i       = '0;
        diff_mode_i  = 1'b0;
        ref_init_i   = 1'b0;
        load_vectors();
        watchdog_cycles = RESET_CYCLES + strobe_q.size() * (MAX_GAP + 1)
                          + tile_passes.size() * (DRAIN_CYCLES + 2) + 50;
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        sidx = 0;
        for (int t = 0; t < tile_passes.size(); t++) begin
            for (int s = 0; s < tile_strobes[t]; s++) begin
                gap = $urandom % (MAX_GAP + 1);
                if (s == tile_strobes[t] - 1) begin
                    while (finish_cnt < t) begin
                        psum_valid_i <= 1'b0;
                        @(posedge clk);
                    end
                end
                repeat (gap) begin
                    psum_valid_i <= 1'b0;
                    @(posedge clk);
                end
                if (s == 0) begin   // previous tile's last strobe is sampled on this edge
                    pass_num_i  <= pass_t'(tile_passes[t]);
                    bias_i      <= tile_bias[t];
                    diff_mode_i <= tile_diff[t];
                    ref_init_i  <= tile_init[t];
                end
                psum_valid_i <= 1'b1;
                psum_i       <= strobe_q[sidx];
                sidx++;
                @(posedge clk);
            end
        end
        psum_valid_i <= 1'b0;
        while (finish_cnt < tile_passes.size()) @(posedge clk);
        repeat (2) @(posedge clk);
        if (byte_idx == exp_byte_q.size() && guard_idx == exp_guard_q.size()) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Run ended with %0d of %0d bytes and %0d of %0d guards",
                     byte_idx, exp_byte_q.size(), guard_idx, exp_guard_q.size());
            stop_on_error();
        end
    end

    // monitor samples the registered outputs on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_valid_o) begin
                if (byte_idx >= exp_byte_q.size()) begin
                    $display("DUT wrote more bytes than the vector file expects");
                    stop_on_error();
                end
                if (tile_bytes != 0) begin   // bytes of one tile come back to back
                    check_value("wb_valid_o", valid_prev, 1'b1);
                end
                check_value("wb_data_o", wb_data_o, exp_byte_q[byte_idx]);
                byte_idx++;
                tile_bytes++;
            end
            if (guard_valid_o) begin
                if (guard_idx >= exp_guard_q.size()) begin
                    $display("DUT sent more guard masks than the vector file expects");
                    stop_on_error();
                end
                check_value("guard_o", guard_o, exp_guard_q[guard_idx]);
                check_value("bytes at guard_valid_o", byte_idx % NUM_LANES, 0);
                guard_idx++;
                tile_guards++;
            end
            if (wb_finish_o) begin
                check_value("wb_valid_o before wb_finish_o", valid_prev, 1'b1);
                check_value("wb_valid_o pulses", tile_bytes, TILE_DEPTH * NUM_LANES);
                check_value("guard_valid_o pulses", tile_guards, TILE_DEPTH);
                tile_bytes  = 0;
                tile_guards = 0;
                finish_cnt++;
            end
            valid_prev = wb_valid_o;
        end
    end

    initial begin
        wait (vectors_loaded === 1'b1);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: tiles not finished within %0d cycles", watchdog_cycles);
        stop_on_error();
    end

endmodule

/* verification/fm_post_props.sv */
// port-level assertions for the post stage, bound into fm_post_top by the testbench
`timescale 1ns/10ps
module fm_post_props
    import fm_post_pkg::*;
#(
    parameter int TILE_DEPTH = 4
) (
    input logic       clk,
    input logic       rst_n,
    input logic       psum_valid_i,
    input pass_t      pass_num_i,
    input pixel_t     wb_data_o,
    input logic       wb_valid_o,
    input lane_mask_t guard_o,
    input logic       guard_valid_o,
    input logic       wb_finish_o
);

    localparam int DRAIN_CYCLES = TILE_DEPTH * NUM_LANES + 2;

    int   strobe_cnt;   // strobes so far in the current tile
    int   drain_left;
    logic tile_end_seen;

    assign tile_end_seen = psum_valid_i && (strobe_cnt == int'(pass_num_i) * TILE_DEPTH - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_cnt <= 0;
            drain_left <= 0;
        end else begin
            if (psum_valid_i) strobe_cnt <= tile_end_seen ? 0 : strobe_cnt + 1;
            if (tile_end_seen) drain_left <= DRAIN_CYCLES - 1;
            else if (drain_left != 0) drain_left <= drain_left - 1;
        end
    end

    a_guard_with_byte: assert property (@(posedge clk) disable iff (!rst_n)
        guard_valid_o |-> wb_valid_o) else $error("guard_valid_o without wb_valid_o");

    a_finish_alone: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_finish_o && wb_valid_o)) else $error("wb_finish_o together with wb_valid_o");

    a_outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({wb_data_o, wb_valid_o, guard_o, guard_valid_o, wb_finish_o}))
        else $error("unknown value on an output after reset");

    a_no_early_tile_end: assert property (@(posedge clk) disable iff (!rst_n)
        tile_end_seen |-> (drain_left == 0)) else $error("tile end while a drain is running");

endmodule

/* source/fm_post_top.sv */
// post-processing stage top: accumulate six-lane psums into ping-pong banks and drain them as bytes
`timescale 1ns/10ps
module fm_post_top
    import fm_post_pkg::*;
#(
    parameter int TILE_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            psum_valid_i,
    input  logic [NUM_LANES*PSUM_WIDTH-1:0] psum_i,        // lane 0 in the low bits
    input  pass_t                           pass_num_i,
    input  pixel_t                          bias_i,
    input  logic                            diff_mode_i,
    input  logic                            ref_init_i,
    output pixel_t                          wb_data_o,
    output logic                            wb_valid_o,
    output lane_mask_t                      guard_o,
    output logic                            guard_valid_o,
    output logic                            wb_finish_o
);

    psum_t psum_lane [NUM_LANES];
    psum_t drain_data [NUM_LANES];   // finished bank at drain_pos

    tile_ctrl_if #(.TILE_DEPTH(TILE_DEPTH)) u_ctrl ();

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            psum_lane[l] = psum_i[l*PSUM_WIDTH +: PSUM_WIDTH];
        end
    end

    tile_counter #(.TILE_DEPTH(TILE_DEPTH)) u_tile_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .psum_valid_i (psum_valid_i),
        .pass_num_i   (pass_num_i),
        .ctrl         (u_ctrl.counter)
    );

    tile_fsm u_tile_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .diff_mode_i (diff_mode_i),
        .ref_init_i  (ref_init_i),
        .wb_finish_o (wb_finish_o),
        .ctrl        (u_ctrl.fsm)
    );

    psum_accum #(.TILE_DEPTH(TILE_DEPTH)) u_psum_accum (
        .clk          (clk),
        .rst_n        (rst_n),
        .psum_valid_i (psum_valid_i),
        .psum_lane_i  (psum_lane),
        .bias_i       (bias_i),
        .ctrl         (u_ctrl.accum),
        .drain_data_o (drain_data)
    );

    write_back #(.TILE_DEPTH(TILE_DEPTH)) u_write_back (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (u_ctrl.wback),
        .drain_data_i  (drain_data),
        .wb_data_o     (wb_data_o),
        .wb_valid_o    (wb_valid_o),
        .guard_o       (guard_o),
        .guard_valid_o (guard_valid_o)
    );

endmodule

/* writeback/write_back.sv */
// serializes the six lane bytes of each position and emits the guard mask with the lane-5 byte
`timescale 1ns/10ps
module write_back
    import fm_post_pkg::*;
#(
    parameter int TILE_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    tile_ctrl_if.wback ctrl,
    input  psum_t      drain_data_i [NUM_LANES],
    output pixel_t     wb_data_o,
    output logic       wb_valid_o,
    output lane_mask_t guard_o,
    output logic       guard_valid_o
);

    localparam lane_sel_t LANE_LAST = lane_sel_t'(NUM_LANES - 1);

    psum_t                lane_val;
    pixel_t               lane_byte;   // diff_relu output lags the drain counters by a cycle
    logic                 vld_d1;
    lane_sel_t            lane_d1;
    logic [NUM_LANES-2:0] guard_acc;   // guard bits of lanes 0..4

    assign lane_val = drain_data_i[ctrl.drain_lane];

    diff_relu #(.TILE_DEPTH(TILE_DEPTH)) u_diff_relu (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .lane_val_i (lane_val),
        .byte_o     (lane_byte)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_d1        <= 1'b0;
            lane_d1       <= '0;
            guard_acc     <= '0;
            wb_data_o     <= '0;
            wb_valid_o    <= 1'b0;
            guard_o       <= '0;
            guard_valid_o <= 1'b0;
        end else begin
            vld_d1     <= ctrl.drain_busy;
            lane_d1    <= ctrl.drain_lane;
            wb_valid_o <= vld_d1;
            guard_valid_o <= vld_d1 && (lane_d1 == LANE_LAST);
            if (vld_d1) begin
                wb_data_o <= lane_byte;
                if (lane_d1 == LANE_LAST) begin
                    guard_o <= {lane_byte != '0, guard_acc};
                end else begin
                    guard_acc[lane_d1] <= (lane_byte != '0);   // guard bit = byte nonzero
                end
            end
        end
    end

endmodule

/* writeback/diff_relu.sv */
// per-lane delta against the stored reference, then ReLU and saturation to one registered byte
`timescale 1ns/10ps
module diff_relu
    import fm_post_pkg::*;
#(
    parameter int TILE_DEPTH = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    tile_ctrl_if.wback ctrl,
    input  psum_t  lane_val_i,
    output pixel_t byte_o
);

    localparam int REF_DEPTH = TILE_DEPTH * NUM_LANES;
    localparam int REF_AW = $clog2(REF_DEPTH);

    pixel_t            ref_mem [REF_DEPTH];   // one entry per position and lane
    logic [REF_AW-1:0] ref_addr;
    pixel_t            ref_rd;
    psum_t             ref_ext, sum_ref, relu_sum, relu_ref, delta;
    pixel_t            byte_nxt;

    function automatic pixel_t clip_byte(input psum_t x);
        if (x < 0) return '0;
        else if (x > 255) return 8'hff;
        else return x[PIXEL_WIDTH-1:0];
    endfunction

    assign ref_addr = REF_AW'(ctrl.drain_pos) * REF_AW'(NUM_LANES) + REF_AW'(ctrl.drain_lane);
    assign ref_rd   = ref_mem[ref_addr];

    always_comb begin
        ref_ext  = ctrl.ref_zero ? '0 : {{(PSUM_WIDTH-PIXEL_WIDTH){ref_rd[7]}}, ref_rd};
        sum_ref  = lane_val_i + ref_ext;
        relu_sum = sum_ref[PSUM_WIDTH-1] ? '0 : sum_ref;
        relu_ref = ref_ext[PSUM_WIDTH-1] ? '0 : ref_ext;
        delta    = relu_sum - relu_ref;     // may go negative, clipped below
        byte_nxt = ctrl.diff_en ? clip_byte(delta) : clip_byte(lane_val_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_o <= '0;
        end else if (ctrl.drain_busy) begin
            byte_o <= byte_nxt;
        end
    end

    // reference becomes low byte of v + ref
    always_ff @(posedge clk) begin
        if (ctrl.drain_busy && ctrl.diff_en) begin
            ref_mem[ref_addr] <= sum_ref[PIXEL_WIDTH-1:0];
        end
    end

endmodule

/* psum/psum_accum.sv */
// ping-pong partial-sum buffer: accumulates passes into the fill bank, adds bias on the last pass
`timescale 1ns/10ps
module psum_accum
    import fm_post_pkg::*;
#(
    parameter int TILE_DEPTH = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   psum_valid_i,
    input  psum_t  psum_lane_i [NUM_LANES],
    input  pixel_t bias_i,
    tile_ctrl_if.accum ctrl,
    output psum_t  drain_data_o [NUM_LANES]
);

    // two banks, TILE_DEPTH positions, six lanes each
    psum_t  bank_mem [2][TILE_DEPTH][NUM_LANES];
    psum_t  acc_nxt [NUM_LANES];
    pixel_t bias_q;      // bias held from the tile's first strobe
    pixel_t bias_sel;
    psum_t  bias_ext;
    logic   tile_start;

    assign tile_start = ctrl.first_pass && (ctrl.accum_pos == '0);
    // single-pass tiles add bias on the very first strobe
    assign bias_sel   = tile_start ? bias_i : bias_q;
    assign bias_ext   = {{(PSUM_WIDTH-PIXEL_WIDTH){1'b0}}, bias_sel};   // zero-extended

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bias_q <= '0;
        end else if (psum_valid_i && tile_start) begin
            bias_q <= bias_i;
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (ctrl.first_pass) begin
                acc_nxt[l] = psum_lane_i[l];
            end else begin
                acc_nxt[l] = psum_lane_i[l] + bank_mem[ctrl.fill_bank][ctrl.accum_pos][l];
            end
            if (ctrl.last_pass) acc_nxt[l] = acc_nxt[l] + bias_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (psum_valid_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                bank_mem[ctrl.fill_bank][ctrl.accum_pos][l] <= acc_nxt[l];
            end
        end
    end

    // drain reads the bank not being filled
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            drain_data_o[l] = bank_mem[!ctrl.fill_bank][ctrl.drain_pos][l];
        end
    end

endmodule

/* source/tile_fsm.sv */
// drain FSM: starts a drain on tile end, swaps psum banks, latches the tile's delta mode
`timescale 1ns/10ps
module tile_fsm
    import fm_post_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   diff_mode_i,
    input  logic   ref_init_i,
    output logic   wb_finish_o,
    tile_ctrl_if.fsm ctrl
);

    drain_state_t state, state_nxt;
    logic         fin_d;   // DR_DONE delayed, lines up with write-back latency

    always_comb begin
        state_nxt = state;
        case (state)
            DR_IDLE: if (ctrl.tile_end) state_nxt = DR_RUN;
            DR_RUN:  if (ctrl.drain_last) state_nxt = DR_DONE;
            DR_DONE: state_nxt = ctrl.tile_end ? DR_RUN : DR_IDLE;
            default: state_nxt = DR_IDLE;
        endcase
    end

    assign ctrl.drain_busy = (state == DR_RUN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= DR_IDLE;
            ctrl.fill_bank <= 1'b0;
            ctrl.diff_en   <= 1'b0;
            ctrl.ref_zero  <= 1'b0;
            fin_d          <= 1'b0;
            wb_finish_o    <= 1'b0;
        end else begin
            state       <= state_nxt;
            fin_d       <= (state == DR_DONE);   // DONE lasts exactly one cycle
            wb_finish_o <= fin_d;
            if (ctrl.tile_end) begin
                // finished bank goes to drain, the other one starts filling
                ctrl.fill_bank <= ~ctrl.fill_bank;
                ctrl.diff_en   <= diff_mode_i;
                ctrl.ref_zero  <= ref_init_i;
            end
        end
    end

endmodule

/* source/tile_counter.sv */
// position/pass counters for accumulation and the lane/position counter for draining a tile
`timescale 1ns/10ps
module tile_counter
    import fm_post_pkg::*;
#(
    parameter int TILE_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  psum_valid_i,
    input  pass_t pass_num_i,
    tile_ctrl_if.counter ctrl
);

    localparam int POS_W = (TILE_DEPTH > 1) ? $clog2(TILE_DEPTH) : 1;
    localparam logic [POS_W-1:0] POS_LAST = POS_W'(TILE_DEPTH - 1);
    localparam lane_sel_t LANE_LAST = lane_sel_t'(NUM_LANES - 1);

    pass_t pass_idx;
    logic  pos_end;

    assign pos_end         = (ctrl.accum_pos == POS_LAST);
    assign ctrl.first_pass = (pass_idx == '0);
    assign ctrl.last_pass  = (pass_idx == pass_num_i - 8'd1);
    assign ctrl.tile_end   = psum_valid_i && ctrl.last_pass && pos_end;
    assign ctrl.drain_last = ctrl.drain_busy && (ctrl.drain_lane == LANE_LAST)
                             && (ctrl.drain_pos == POS_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl.accum_pos  <= '0;
            pass_idx        <= '0;
            ctrl.drain_pos  <= '0;
            ctrl.drain_lane <= '0;
        end else begin
            if (psum_valid_i) begin
                ctrl.accum_pos <= pos_end ? '0 : ctrl.accum_pos + 1'b1;
                if (pos_end) pass_idx <= ctrl.last_pass ? '0 : pass_idx + 8'd1;
            end
            if (ctrl.drain_busy) begin   // lane first, then position
                if (ctrl.drain_lane == LANE_LAST) begin
                    ctrl.drain_lane <= '0;
                    ctrl.drain_pos  <= (ctrl.drain_pos == POS_LAST) ? '0 : ctrl.drain_pos + 1'b1;
                end else begin
                    ctrl.drain_lane <= ctrl.drain_lane + 3'd1;
                end
            end
        end
    end

endmodule

/* common/tile_ctrl_if.sv */
// control bundle between counters, drain FSM, psum buffer and write-back; one instance in the top
`timescale 1ns/10ps
interface tile_ctrl_if
    import fm_post_pkg::*;
#(
    parameter int TILE_DEPTH = 4
) ();
    localparam int POS_W = (TILE_DEPTH > 1) ? $clog2(TILE_DEPTH) : 1;

    // accumulation side, from tile_counter
    logic             tile_end;     // last strobe of last pass
    logic             last_pass;
    logic             first_pass;
    logic [POS_W-1:0] accum_pos;

    // from tile_fsm
    logic             fill_bank;    // bank being accumulated
    logic             drain_busy;
    logic             diff_en;      // latched per tile
    logic             ref_zero;

    // drain side, from tile_counter
    logic [POS_W-1:0] drain_pos;
    lane_sel_t        drain_lane;
    logic             drain_last;   // final byte of the tile

    modport counter (output tile_end, last_pass, first_pass, accum_pos,
                     output drain_pos, drain_lane, drain_last, input drain_busy);
    modport fsm     (input tile_end, drain_last,
                     output fill_bank, drain_busy, diff_en, ref_zero);
    modport accum   (input first_pass, last_pass, accum_pos, fill_bank, drain_pos);
    modport wback   (input drain_busy, diff_en, ref_zero, drain_pos, drain_lane);

endinterface

/* common/fm_post_pkg.sv */
// shared widths, lane types and drain FSM encoding, imported by every block of the post stage
package fm_post_pkg;

    // parallel output channels per position
    localparam int NUM_LANES = 6;

    localparam int PSUM_WIDTH = 32;
    localparam int PIXEL_WIDTH = 8;

    // one lane's partial sum or accumulated value
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    // output byte, also one reference entry
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // one bit per lane, used for the guard mask
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // pass count and pass index
    typedef logic [7:0] pass_t;

    // lane index during drain, 0..NUM_LANES-1
    typedef logic [2:0] lane_sel_t;

    // drain FSM
    typedef enum logic [1:0] {
        DR_IDLE = 2'd0,
        DR_RUN  = 2'd1,
        DR_DONE = 2'd2
    } drain_state_t;

endpackage
